// File: alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_types_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // Signed compare
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            // Immediate already shifted up by decode
            ALU_LUI: result = b;
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: control_unit.sv
// Instruction decode and immediate extend
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import cpu_types_pkg::*;
    import pipe_pkg::*;
(
    input  instr_t    instr,
    input  logic      equal,
    input  word_t     pc_plus4,
    output ctrl_t     ctrl,
    output word_t     imm_ext,
    output reg_addr_t wsel,
    output logic      branch_taken,
    output logic      jump,
    output word_t     target
);

    word_t branch_off;

    always_comb begin
        ctrl    = CTRL_NOP;
        imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
        wsel    = instr.i.rt;
        case (instr.r.opcode)
            RTYPE: begin
                wsel           = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    ADDU:    ctrl.alu_op = ALU_ADD;
                    SUBU:    ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    default: ctrl = CTRL_NOP;
                endcase
            end
            ADDIU: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ORI: begin
                imm_ext        = {16'h0000, instr.i.imm};
                ctrl.alu_op    = ALU_OR;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            LUI: begin
                imm_ext        = {instr.i.imm, 16'h0000};
                ctrl.alu_op    = ALU_LUI;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            LW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            HALT:    ctrl.halt = 1'b1;
            default: ctrl = CTRL_NOP;
        endcase
    end

    // Word offset relative to the next instruction
    assign branch_off = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

    assign branch_taken = (instr.i.opcode == BEQ && equal)
                       || (instr.i.opcode == BNE && !equal);
    assign jump = (instr.j.opcode == J);

    assign target = jump ? {pc_plus4[31:28], instr.j.addr, 2'b00}
                         : pc_plus4 + branch_off;

endmodule

`default_nettype wire

// File: cpu_types_pkg.sv
// MIPS subset instruction types
`default_nettype none

package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Fetch starts here after reset
    localparam word_t PC_INIT = 32'h0000_0000;

    // Kept opcodes only
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        ORI   = 6'h0d,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] addr;
    } j_t;

    // Same fetched word seen through each format
    typedef union packed {
        r_t r;
        i_t i;
        j_t j;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

endpackage

`default_nettype wire

// File: datapath.sv
// Five-stage pipelined datapath
`timescale 1ns/1ps
`default_nettype none

module datapath
    import cpu_types_pkg::*;
    import pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    output imem_req_t imem_req,
    input  logic      imem_ready,
    input  word_t     imem_load,
    output dmem_req_t dmem_req,
    input  logic      dmem_ready,
    input  word_t     dmem_load,
    output logic      halt
);

    word_t     pc_q;
    word_t     pc_plus4;
    word_t     pc_next;
    ifid_t     ifid_q;
    idex_t     idex_q;
    exmem_t    exmem_q;
    memwb_t    memwb_q;
    logic      fetch_stop_q;
    logic      halt_q;

    logic      frozen;
    logic      advance;
    logic      stall_id;
    logic      redirect;
    logic      flush_ifid;

    word_t     rdat1;
    word_t     rdat2;
    ctrl_t     id_ctrl;
    word_t     id_imm_ext;
    reg_addr_t id_wsel;
    logic      id_branch_taken;
    logic      id_jump;
    word_t     id_target;
    logic      id_uses_rt;
    logic      id_is_branch;

    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    word_t     ex_a;
    word_t     ex_fwd_b;
    word_t     ex_b;
    word_t     ex_result;
    word_t     mem_result;

    // Memory ports
    assign imem_req = '{valid: !fetch_stop_q, addr: pc_q};
    assign dmem_req = '{valid: exmem_q.ctrl.mem_read || exmem_q.ctrl.mem_write,
                        write: exmem_q.ctrl.mem_write,
                        addr:  exmem_q.alu_result,
                        store: exmem_q.store};

    // Any unanswered request holds the whole pipeline
    assign frozen  = (imem_req.valid && !imem_ready) || (dmem_req.valid && !dmem_ready);
    assign advance = !frozen;

    assign redirect   = (id_branch_taken || id_jump) && !stall_id;
    // Wrong-path or missing fetch becomes a bubble
    assign flush_ifid = redirect || id_ctrl.halt || !imem_req.valid;
    assign pc_plus4   = pc_q + 32'd4;
    assign pc_next    = redirect ? id_target : pc_plus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc_q         <= PC_INIT;
            ifid_q       <= '0;
            fetch_stop_q <= 1'b0;
        end else if (advance && !stall_id) begin
            pc_q <= pc_next;
            if (flush_ifid) begin
                ifid_q <= '0;
            end else begin
                ifid_q <= '{instr: imem_load, pc_plus4: pc_plus4};
            end
            if (id_ctrl.halt) begin
                fetch_stop_q <= 1'b1;
            end
        end
    end

    // ID stage
    assign id_is_branch = (ifid_q.instr.i.opcode == BEQ) || (ifid_q.instr.i.opcode == BNE);
    assign id_uses_rt   = (ifid_q.instr.i.opcode == RTYPE) || (ifid_q.instr.i.opcode == SW)
                       || id_is_branch;

    register_file rf (
        .CLK   (CLK),
        .reset (reset),
        .rsel1 (ifid_q.instr.r.rs),
        .rsel2 (ifid_q.instr.r.rt),
        .wsel  (memwb_q.wsel),
        .wen   (memwb_q.reg_write),
        .wdat  (memwb_q.result),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    control_unit cu (
        .instr        (ifid_q.instr),
        .equal        (rdat1 == rdat2),
        .pc_plus4     (ifid_q.pc_plus4),
        .ctrl         (id_ctrl),
        .imm_ext      (id_imm_ext),
        .wsel         (id_wsel),
        .branch_taken (id_branch_taken),
        .jump         (id_jump),
        .target       (id_target)
    );

    hazard_unit hz (
        .id_rs         (ifid_q.instr.r.rs),
        .id_rt         (ifid_q.instr.r.rt),
        .id_uses_rt    (id_uses_rt),
        .id_is_branch  (id_is_branch),
        .ex_wsel       (idex_q.wsel),
        .mem_wsel      (exmem_q.wsel),
        .wb_wsel       (memwb_q.wsel),
        .ex_reg_write  (idex_q.ctrl.reg_write),
        .mem_reg_write (exmem_q.ctrl.reg_write),
        .wb_reg_write  (memwb_q.reg_write),
        .ex_mem_read   (idex_q.ctrl.mem_read),
        .ex_rs         (idex_q.rs),
        .ex_rt         (idex_q.rt),
        .stall_id      (stall_id),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    // EX operand selection
    always_comb begin
        case (fwd_a)
            FWD_MEM: ex_a = exmem_q.alu_result;
            FWD_WB:  ex_a = memwb_q.result;
            default: ex_a = idex_q.rdat1;
        endcase
        case (fwd_b)
            FWD_MEM: ex_fwd_b = exmem_q.alu_result;
            FWD_WB:  ex_fwd_b = memwb_q.result;
            default: ex_fwd_b = idex_q.rdat2;
        endcase
    end

    assign ex_b = idex_q.ctrl.alu_src ? idex_q.imm_ext : ex_fwd_b;

    alu ex_alu (
        .op     (idex_q.ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    assign mem_result = exmem_q.ctrl.mem_read ? dmem_load : exmem_q.alu_result;

    always_ff @(posedge CLK) begin
        if (reset) begin
            idex_q  <= '0;
            exmem_q <= '0;
            memwb_q <= '0;
        end else if (advance) begin
            if (stall_id) begin
                idex_q <= '0;
            end else begin
                idex_q <= '{ctrl: id_ctrl, rdat1: rdat1, rdat2: rdat2,
                            imm_ext: id_imm_ext, rs: ifid_q.instr.r.rs,
                            rt: ifid_q.instr.r.rt, wsel: id_wsel};
            end
            exmem_q <= '{ctrl: idex_q.ctrl, alu_result: ex_result,
                         store: ex_fwd_b, wsel: idex_q.wsel};
            memwb_q <= '{reg_write: exmem_q.ctrl.reg_write, halt: exmem_q.ctrl.halt,
                         result: mem_result, wsel: exmem_q.wsel};
        end
    end

    // Halt sticks once it reaches write-back
    always_ff @(posedge CLK) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (memwb_q.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt = halt_q || memwb_q.halt;

endmodule

`default_nettype wire

// File: files.f
cpu_types_pkg.sv
pipe_pkg.sv
register_file.sv
control_unit.sv
alu.sv
hazard_unit.sv
datapath.sv
tb_datapath.sv
+incdir+.

// File: hazard_unit.sv
// Stall detection and EX forwarding
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import cpu_types_pkg::*;
    import pipe_pkg::*;
(
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      id_uses_rt,
    input  logic      id_is_branch,
    input  reg_addr_t ex_wsel,
    input  reg_addr_t mem_wsel,
    input  reg_addr_t wb_wsel,
    input  logic      ex_reg_write,
    input  logic      mem_reg_write,
    input  logic      wb_reg_write,
    input  logic      ex_mem_read,
    input  reg_addr_t ex_rs,
    input  reg_addr_t ex_rt,
    output logic      stall_id,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b
);

    logic ex_hits_rs;
    logic ex_hits_rt;
    logic mem_hits_rs;
    logic mem_hits_rt;
    logic load_use;
    logic branch_wait;

    // A write to register 0 never counts as a producer
    function automatic logic hits(logic wr, reg_addr_t dst, reg_addr_t src);
        return wr && dst != '0 && dst == src;
    endfunction

    assign ex_hits_rs  = hits(ex_reg_write, ex_wsel, id_rs);
    assign ex_hits_rt  = hits(ex_reg_write, ex_wsel, id_rt);
    assign mem_hits_rs = hits(mem_reg_write, mem_wsel, id_rs);
    assign mem_hits_rt = hits(mem_reg_write, mem_wsel, id_rt);

    assign load_use    = ex_mem_read && (ex_hits_rs || (id_uses_rt && ex_hits_rt));
    // Branch compares in ID, so wait until the source is in WB
    assign branch_wait = id_is_branch && (ex_hits_rs || ex_hits_rt || mem_hits_rs || mem_hits_rt);
    assign stall_id    = load_use || branch_wait;

    // Youngest producer first
    function automatic fwd_sel_t pick(reg_addr_t src);
        if (hits(mem_reg_write, mem_wsel, src)) begin
            return FWD_MEM;
        end else if (hits(wb_reg_write, wb_wsel, src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick(ex_rs);
        fwd_b = pick(ex_rt);
    end

endmodule

`default_nettype wire

// File: pipe_pkg.sv
// Pipeline and memory port structures
`default_nettype none

package pipe_pkg;

    import cpu_types_pkg::*;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    halt;
    } ctrl_t;

    // Decoded bubble that does nothing in any stage
    localparam ctrl_t CTRL_NOP = '{alu_op: ALU_ADD, default: 1'b0};

    typedef struct packed {
        instr_t instr;
        word_t  pc_plus4;
    } ifid_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rdat1;
        word_t     rdat2;
        word_t     imm_ext;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t wsel;
    } idex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store;
        reg_addr_t wsel;
    } exmem_t;

    typedef struct packed {
        logic      reg_write;
        logic      halt;
        word_t     result;
        reg_addr_t wsel;
    } memwb_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t store;
    } dmem_req_t;

    // Operand source for EX
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: register_file.sv
// Register file with write-through
`timescale 1ns/1ps
`default_nettype none

module register_file
    import cpu_types_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  reg_addr_t rsel1,
    input  reg_addr_t rsel2,
    input  reg_addr_t wsel,
    input  logic      wen,
    input  word_t     wdat,
    output word_t     rdat1,
    output word_t     rdat2
);

    // Register 0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // Value being written this cycle wins over the stored one
    function automatic word_t read_port(reg_addr_t sel);
        if (sel == '0) begin
            return '0;
        end else if (wen && sel == wsel) begin
            return wdat;
        end
        return regs[sel];
    endfunction

    always_comb begin
        rdat1 = read_port(rsel1);
        rdat2 = read_port(rsel2);
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_datapath

out=$(./obj_dir/Vtb_datapath)
echo "$out"

echo "$out" | grep -q "All tests passed!"

// File: isa_model.svh
// Program generator and reference model
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

function automatic word_t itype_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t rtype_word(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
    return {RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

// Body instruction at word index idx where branches and jumps skip 1 to 4 words forward
function automatic word_t random_instr(int unsigned idx);
    logic [31:0] r;
    logic [31:0] v;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] skip;
    logic [15:0] offs;
    r = next_rand();
    v = next_rand();
    rs = {1'b0, r[7:4]};
    rt = {1'b0, r[11:8]};
    rd = {1'b0, r[15:12]};
    skip = {14'd0, r[17:16]} + 16'd1;
    offs = {8'd0, v[5:0], 2'b00};
    case (r[3:0])
        4'd0:        return rtype_word(ADDU, rs, rt, rd);
        4'd1:        return rtype_word(SUBU, rs, rt, rd);
        4'd2:        return rtype_word(AND, rs, rt, rd);
        4'd3:        return rtype_word(OR, rs, rt, rd);
        4'd4:        return rtype_word(SLT, rs, rt, rd);
        4'd5, 4'd6:  return itype_word(ADDIU, rs, rt, v[31:16]);
        4'd7:        return itype_word(ORI, rs, rt, v[31:16]);
        4'd8:        return itype_word(LUI, 5'd0, rt, v[31:16]);
        4'd9, 4'd10: return itype_word(LW, 5'd0, rt, offs);
        4'd11:       return itype_word(SW, 5'd0, rt, offs);
        4'd12:       return itype_word(BEQ, rs, rt, skip);
        4'd13:       return itype_word(BNE, rs, rt, skip);
        4'd14:       return {J, 26'(idx + 1) + {24'd0, r[17:16]} + 26'd1};
        default:     return rtype_word(ADDU, rs, rt, rd);
    endcase
endfunction

task automatic build_program();
    int unsigned n;
    logic [31:0] seed;
    n = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[8'(i)] = '0;
    end
    // Seed registers 1 to 8
    for (int r = 1; r <= 8; r++) begin
        seed = next_rand();
        imem[8'(n)] = itype_word(LUI, 5'd0, 5'(r), seed[31:16]);
        imem[8'(n + 1)] = itype_word(ORI, 5'(r), 5'(r), seed[15:0]);
        n += 2;
    end
    for (int i = 0; i < BODY_LEN; i++) begin
        imem[8'(n)] = random_instr(n);
        n++;
    end
    // Dump the whole register file
    for (int r = 1; r < 32; r++) begin
        imem[8'(n)] = itype_word(SW, 5'd0, 5'(r), 16'(RESULT_BASE + 4 * (r - 1)));
        n++;
    end
    imem[8'(n)] = {HALT, 26'd0};
    for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[8'(i)] = fill_word(8'(i));
    end
endtask

task automatic run_model();
    word_t  regs [32];
    word_t  mem [DMEM_WORDS];
    instr_t ins;
    word_t  pc;
    word_t  simm;
    word_t  sum;
    word_t  res;
    logic   wr;
    logic   done;
    regs = '{default: '0};
    for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[8'(i)] = fill_word(8'(i));
    end
    expected.delete();
    pc = '0;
    done = 1'b0;
    while (!done) begin
        ins = imem[pc[9:2]];
        simm = {{16{ins.i.imm[15]}}, ins.i.imm};
        sum = regs[ins.i.rs] + simm;
        res = '0;
        wr = ins.i.opcode inside {RTYPE, ADDIU, ORI, LUI, LW};
        pc = pc + 32'd4;
        case (ins.i.opcode)
            RTYPE: begin
                case (ins.r.funct)
                    ADDU:    res = regs[ins.r.rs] + regs[ins.r.rt];
                    SUBU:    res = regs[ins.r.rs] - regs[ins.r.rt];
                    AND:     res = regs[ins.r.rs] & regs[ins.r.rt];
                    OR:      res = regs[ins.r.rs] | regs[ins.r.rt];
                    SLT:     res = {31'd0, $signed(regs[ins.r.rs]) < $signed(regs[ins.r.rt])};
                    default: wr = 1'b0;
                endcase
            end
            ADDIU: res = sum;
            ORI:   res = regs[ins.i.rs] | {16'd0, ins.i.imm};
            LUI:   res = {ins.i.imm, 16'd0};
            LW:    res = mem[sum[9:2]];
            SW: begin
                mem[sum[9:2]] = regs[ins.i.rt];
                expected.push_back({sum, regs[ins.i.rt]});
            end
            BEQ: if (regs[ins.i.rs] == regs[ins.i.rt]) begin
                pc = pc + {simm[29:0], 2'b00};
            end
            BNE: if (regs[ins.i.rs] != regs[ins.i.rt]) begin
                pc = pc + {simm[29:0], 2'b00};
            end
            J:       pc = {pc[31:28], ins.j.addr, 2'b00};
            HALT:    done = 1'b1;
            default: res = '0;
        endcase
        if (wr) begin
            regs[ins.i.opcode == RTYPE ? ins.r.rd : ins.i.rt] = res;
        end
        // Register 0 stays zero
        regs[0] = '0;
    end
endtask

`endif

// File: tb_datapath.sv
// Pipelined datapath testbench
`timescale 1ns/1ps
`default_nettype none

module tb_datapath
    import cpu_types_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_PROGRAMS   = 20;
    localparam int PROGRAM_CYCLES = 4000;
    localparam int MAX_CYCLES     = NUM_PROGRAMS * PROGRAM_CYCLES;
    // Leaves room for reset and drain inside one program's share
    localparam int HALT_LIMIT     = PROGRAM_CYCLES - 100;
    localparam int DRAIN_CYCLES   = 8;
    localparam int IMEM_WORDS     = 256;
    localparam int DMEM_WORDS     = 256;
    localparam int BODY_LEN       = 60;
    localparam int RESULT_BASE    = 256;

    logic      CLK = 1'b0;
    logic      reset;
    imem_req_t imem_req;
    logic      imem_ready;
    word_t     imem_load;
    dmem_req_t dmem_req;
    logic      dmem_ready;
    word_t     dmem_load;
    logic      halt;

    word_t       imem [IMEM_WORDS];
    word_t       dmem [DMEM_WORDS];
    // Expected stores in commit order with the address in the upper half
    logic [63:0] expected [$];
    logic [31:0] rng_state = 32'hfd54_7c2a;
    int          errors;
    int          stores_checked;
    int          prog_stores;
    int          cycle_count;
    imem_req_t   held_imem;
    dmem_req_t   held_dmem;
    logic        imem_waiting;
    logic        dmem_waiting;

    always #5 CLK = ~CLK;

    datapath uut (
        .CLK        (CLK),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_ready (imem_ready),
        .imem_load  (imem_load),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_load  (dmem_load),
        .halt       (halt)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Initial data memory contents hashed from the byte address
    function automatic word_t fill_word(logic [7:0] idx);
        return ({22'd0, idx, 2'b00} * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    `include "isa_model.svh"

    task automatic check_store(word_t addr, word_t data);
        logic [63:0] exp;
        stores_checked++;
        prog_stores++;
        if (halt) begin
            errors++;
            $display("Store to %h was committed after halt rose", addr);
        end
        if (expected.size() == 0) begin
            errors++;
            $display("Store to %h was committed but the model has no store left", addr);
        end else begin
            exp = expected.pop_front();
            if (addr != exp[63:32]) begin
                errors++;
                $display("FAILED at %0t: dmem_req.addr = %h, expected %h", $time, addr, exp[63:32]);
            end
            if (data != exp[31:0]) begin
                errors++;
                $display("FAILED at %0t: dmem_req.store = %h, expected %h", $time, data, exp[31:0]);
            end
        end
    endtask

    // Memory answers for the coming rising edge with one shared wait state for both ports
    task automatic serve_memory();
        logic [31:0] r;
        logic        ready;
        if (imem_waiting && imem_req != held_imem) begin
            errors++;
            $display("FAILED at %0t: imem_req = %h, expected %h", $time, imem_req, held_imem);
        end
        if (dmem_waiting && dmem_req != held_dmem) begin
            errors++;
            $display("FAILED at %0t: dmem_req = %h, expected %h", $time, dmem_req, held_dmem);
        end
        r = next_rand();
        ready = r[1:0] != 2'b00;
        imem_ready = ready;
        dmem_ready = ready;
        imem_load = imem[imem_req.addr[9:2]];
        // Read data only for a valid read request
        if (dmem_req.valid && !dmem_req.write) begin
            dmem_load = dmem[dmem_req.addr[9:2]];
        end else begin
            dmem_load = '0;
        end
        if (ready && dmem_req.valid && dmem_req.write) begin
            check_store(dmem_req.addr, dmem_req.store);
            dmem[dmem_req.addr[9:2]] = dmem_req.store;
        end
        held_imem = imem_req;
        held_dmem = dmem_req;
        imem_waiting = imem_req.valid && !ready;
        dmem_waiting = dmem_req.valid && !ready;
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        imem_ready = 1'b0;
        dmem_ready = 1'b0;
        imem_waiting = 1'b0;
        dmem_waiting = 1'b0;
        repeat (3) @(negedge CLK);
        reset = 1'b0;
        if (dmem_req.valid !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: dmem_req.valid = %b, expected 0", $time, dmem_req.valid);
        end
        if (halt !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: halt = %b, expected 0", $time, halt);
        end
        if (imem_req.valid !== 1'b1) begin
            errors++;
            $display("FAILED at %0t: imem_req.valid = %b, expected 1", $time, imem_req.valid);
        end
        if (imem_req.addr !== 32'h0000_0000) begin
            errors++;
            $display("FAILED at %0t: imem_req.addr = %h, expected 00000000", $time,
                     imem_req.addr);
        end
    endtask

    task automatic run_program(int p);
        int waited;
        int exp_count;
        build_program();
        run_model();
        exp_count = expected.size();
        prog_stores = 0;
        reset_dut();
        waited = 0;
        while (!halt && waited < HALT_LIMIT) begin
            serve_memory();
            @(negedge CLK);
            waited++;
        end
        if (!halt) begin
            errors++;
            $display("Program %0d did not raise halt within %0d cycles", p, HALT_LIMIT);
        end else begin
            repeat (DRAIN_CYCLES) begin
                serve_memory();
                @(negedge CLK);
                if (!halt) begin
                    errors++;
                    $display("FAILED at %0t: halt = %b, expected 1", $time, halt);
                end
            end
        end
        if (prog_stores != exp_count) begin
            errors++;
            $display("FAILED at %0t: store count = %0d, expected %0d", $time, prog_stores,
                     exp_count);
        end
    endtask

    initial begin
        errors = 0;
        stores_checked = 0;
        prog_stores = 0;
        reset = 1'b1;
        imem_ready = 1'b0;
        dmem_ready = 1'b0;
        imem_load = '0;
        dmem_load = '0;
        imem_waiting = 1'b0;
        dmem_waiting = 1'b0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("Programs %0d, stores checked %0d, errors %0d", NUM_PROGRAMS, stores_checked,
                 errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_count);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
